// File: bench/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;

    logic                  I_sys_clk;
    logic                  rst_n;
    rv_isa_pkg::xlen_t     imem_addr;
    rv_isa_pkg::inst_t     imem_data;
    rv_isa_pkg::xlen_t     dmem_addr;
    logic                  dmem_wen;
    rv_isa_pkg::strb_t     dmem_wstrb;
    rv_isa_pkg::xlen_t     dmem_wdata;
    rv_isa_pkg::xlen_t     dmem_rdata;
    logic                  halted;

    rv_isa_pkg::inst_t     imem [64];
    rv_isa_pkg::xlen_t     dmem [64];
    rv_isa_pkg::xlen_t     exp_addr [32];
    rv_isa_pkg::strb_t     exp_strb [32];
    rv_isa_pkg::xlen_t     exp_data [32];
    rv_isa_pkg::xlen_t     ebreak_pc;
    int                    prog_len;
    int                    exp_len;
    int                    store_idx;
    int                    cycles;
    int                    limit;
    int                    seed;

    rv_core dut_i (
        .I_sys_clk  (I_sys_clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    always #20 I_sys_clk = !I_sys_clk;

    // both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[8:3]];

    ////////////////////
    // reporting
    ////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_xlen(input string name, input rv_isa_pkg::xlen_t got,
                              input rv_isa_pkg::xlen_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_strb(input string name, input rv_isa_pkg::strb_t got,
                              input rv_isa_pkg::strb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    ////////////////////
    // instruction encoders
    ////////////////////

    function automatic rv_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // bytes not under the strobe carry no meaning
    function automatic rv_isa_pkg::xlen_t strb_mask(input rv_isa_pkg::strb_t strb);
        rv_isa_pkg::xlen_t m;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = strb[b] ? 8'hff : 8'h00;
        end
        return m;
    endfunction

    task automatic put(input rv_isa_pkg::inst_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic expect_store(input rv_isa_pkg::xlen_t addr, input rv_isa_pkg::strb_t strb,
                                input rv_isa_pkg::xlen_t data);
        exp_addr[exp_len] = addr;
        exp_strb[exp_len] = strb;
        exp_data[exp_len] = data;
        exp_len++;
    endtask

    ////////////////////
    // store monitor and data memory
    ////////////////////

    always @(posedge I_sys_clk) begin
        if (rst_n && dmem_wen) begin
            if (store_idx >= exp_len) begin
                fail_run($sformatf("unexpected store to address %h", dmem_addr));
            end else begin
                check_xlen("dmem_addr", dmem_addr, exp_addr[store_idx]);
                check_strb("dmem_wstrb", dmem_wstrb, exp_strb[store_idx]);
                check_xlen("dmem_wdata", dmem_wdata & strb_mask(dmem_wstrb),
                           exp_data[store_idx] & strb_mask(exp_strb[store_idx]));
                dmem[dmem_addr[8:3]] = (dmem[dmem_addr[8:3]] & ~strb_mask(dmem_wstrb)) |
                                       (dmem_wdata & strb_mask(dmem_wstrb));
                store_idx++;
            end
        end
    end

    always @(posedge I_sys_clk) begin
        cycles++;
        if (cycles > limit) begin
            fail_run("timeout, core never halted");
        end
    end

    ////////////////////
    // program and expected stores
    ////////////////////

    initial begin
        I_sys_clk = 1'b0;
        rst_n     = 1'b0;
        prog_len  = 0;
        exp_len   = 0;
        store_idx = 0;
        cycles    = 0;
        seed      = 31;
        limit     = 1000;
        ebreak_pc = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = {32'(i * 8) ^ 32'(($random(seed))), ~32'(i * 8)};
        end

        put(enc_i(12'd100, 5'd0, 3'd0, 5'd1, 7'h13));
        put(enc_i(12'hff9, 5'd0, 3'd0, 5'd2, 7'h13));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        put(enc_s(12'h000, 5'd3, 3'd3));
        put(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, 7'h33));
        put(enc_s(12'h008, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3, 7'h33));
        put(enc_s(12'h010, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3, 7'h33));
        put(enc_s(12'h018, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, 7'h33));
        put(enc_s(12'h020, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd3, 7'h33));
        put(enc_s(12'h028, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd3, 7'h33));
        put(enc_s(12'h030, 5'd3, 3'd3));
        put({20'h12345, 5'd3, 7'h37});
        put(enc_s(12'h038, 5'd3, 3'd3));
        put({20'h00001, 5'd3, 7'h17});
        put(enc_s(12'h040, 5'd3, 3'd3));
        // shifts and word forms
        put(enc_i(12'd40, 5'd1, 3'd1, 5'd3, 7'h13));
        put(enc_s(12'h048, 5'd3, 3'd3));
        put(enc_i(12'h404, 5'd2, 3'd5, 5'd3, 7'h13));
        put(enc_s(12'h050, 5'd3, 3'd3));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd5, 5'd3, 7'h3b));
        put(enc_s(12'h058, 5'd3, 3'd3));
        put({20'h80000, 5'd5, 7'h37});
        put(enc_i(12'hfff, 5'd5, 3'd0, 5'd3, 7'h1b));
        put(enc_s(12'h060, 5'd3, 3'd3));
        // sub-word stores into one doubleword
        put(enc_s(12'h101, 5'd1, 3'd0));
        put(enc_s(12'h102, 5'd2, 3'd1));
        put(enc_s(12'h104, 5'd5, 3'd2));
        // loads back, each stored as a doubleword
        put(enc_i(12'h102, 5'd0, 3'd0, 5'd6, 7'h03));
        put(enc_s(12'h068, 5'd6, 3'd3));
        put(enc_i(12'h102, 5'd0, 3'd4, 5'd6, 7'h03));
        put(enc_s(12'h070, 5'd6, 3'd3));
        put(enc_i(12'h102, 5'd0, 3'd1, 5'd6, 7'h03));
        put(enc_s(12'h078, 5'd6, 3'd3));
        put(enc_i(12'h104, 5'd0, 3'd2, 5'd6, 7'h03));
        put(enc_s(12'h080, 5'd6, 3'd3));
        put(enc_i(12'h104, 5'd0, 3'd6, 5'd6, 7'h03));
        put(enc_s(12'h088, 5'd6, 3'd3));
        // branches and jumps, skipped stores are markers
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd0));
        put(enc_s(12'h090, 5'd1, 3'd3));
        put(enc_b(13'd8, 5'd2, 5'd1, 3'd1));
        put(enc_s(12'h098, 5'd2, 3'd3));
        put(enc_b(13'd8, 5'd1, 5'd1, 3'd0));
        put(enc_s(12'h0a0, 5'd2, 3'd3));
        put(enc_b(13'd8, 5'd1, 5'd1, 3'd1));
        put(enc_s(12'h0a8, 5'd2, 3'd3));
        put(enc_j(21'd8, 5'd7));
        put(enc_s(12'h0b0, 5'd2, 3'd3));
        put(enc_s(12'h0b8, 5'd7, 3'd3));
        put(enc_i(12'd225, 5'd0, 3'd0, 5'd8, 7'h13));
        put(enc_i(12'd0, 5'd8, 3'd0, 5'd9, 7'h67));
        put(enc_s(12'h0c0, 5'd2, 3'd3));
        put(enc_s(12'h0c8, 5'd9, 3'd3));
        // the pc parks on the ebreak word
        ebreak_pc = `RV_RESET_PC + rv_isa_pkg::xlen_t'(prog_len * 4);
        put(`RV_EBREAK);
        put(enc_s(12'h0d0, 5'd1, 3'd3));
        put(enc_s(12'h0d8, 5'd2, 3'd3));

        expect_store(64'h000, 8'hff, 64'h0000_0000_0000_005d);
        expect_store(64'h008, 8'hff, 64'hffff_ffff_ffff_ff95);
        expect_store(64'h010, 8'hff, 64'hffff_ffff_ffff_ff9d);
        expect_store(64'h018, 8'hff, 64'hffff_ffff_ffff_fffd);
        expect_store(64'h020, 8'hff, 64'h0000_0000_0000_0060);
        expect_store(64'h028, 8'hff, 64'h0000_0000_0000_0001);
        expect_store(64'h030, 8'hff, 64'h0000_0000_0000_0000);
        expect_store(64'h038, 8'hff, 64'h0000_0000_1234_5000);
        expect_store(64'h040, 8'hff, 64'h0000_0000_0000_1048);
        expect_store(64'h048, 8'hff, 64'h0000_6400_0000_0000);
        expect_store(64'h050, 8'hff, 64'hffff_ffff_ffff_ffff);
        expect_store(64'h058, 8'hff, 64'h0000_0000_0fff_ffff);
        expect_store(64'h060, 8'hff, 64'h0000_0000_7fff_ffff);
        expect_store(64'h100, 8'h02, 64'h0000_0000_0000_6400);
        expect_store(64'h100, 8'h0c, 64'hffff_ffff_fff9_0000);
        expect_store(64'h100, 8'hf0, 64'h8000_0000_0000_0000);
        expect_store(64'h068, 8'hff, 64'hffff_ffff_ffff_fff9);
        expect_store(64'h070, 8'hff, 64'h0000_0000_0000_00f9);
        expect_store(64'h078, 8'hff, 64'hffff_ffff_ffff_fff9);
        expect_store(64'h080, 8'hff, 64'hffff_ffff_8000_0000);
        expect_store(64'h088, 8'hff, 64'h0000_0000_8000_0000);
        expect_store(64'h090, 8'hff, 64'h0000_0000_0000_0064);
        expect_store(64'h0a8, 8'hff, 64'hffff_ffff_ffff_fff9);
        // link values of jal and jalr
        expect_store(64'h0b8, 8'hff, 64'h0000_0000_0000_00cc);
        expect_store(64'h0c8, 8'hff, 64'h0000_0000_0000_00dc);

        limit = prog_len * 2 + 20;

        repeat (4) @(posedge I_sys_clk);
        // reset state, settled since the first edge
        check_xlen("imem_addr", imem_addr, `RV_RESET_PC);
        check_bit("halted", halted, 1'b0);
        rst_n <= 1'b1;

        wait (halted === 1'b1);
        // a few more cycles to catch stores past the ebreak
        repeat (4) @(posedge I_sys_clk);
        check_bit("halted", halted, 1'b1);
        check_xlen("imem_addr", imem_addr, ebreak_pc);
        if (store_idx == exp_len) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d stores seen", store_idx, exp_len));
        end
    end

endmodule

`default_nettype wire

// File: common/dec_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dec_ctrl_if;

    rv_isa_pkg::xlen_t      imm;
    rv_ctrl_pkg::alu_op_e   alu_op;
    rv_ctrl_pkg::opnum1_e   opnum1_sel;
    rv_ctrl_pkg::opnum2_e   opnum2_sel;
    logic                   word_op;
    logic                   reg_wen;
    rv_ctrl_pkg::regin_e    regin_sel;
    logic                   mem_wen;
    logic                   mem_ren;
    rv_ctrl_pkg::mem_size_e mem_size;
    logic                   mem_sext;
    rv_ctrl_pkg::dnpc_e     dnpc_sel;

    modport decoder (
        output imm, alu_op, opnum1_sel, opnum2_sel, word_op, reg_wen, regin_sel,
        output mem_wen, mem_ren, mem_size, mem_sext, dnpc_sel
    );

    modport exec (
        input imm, alu_op, opnum1_sel, opnum2_sel, word_op, reg_wen, regin_sel,
        input mem_wen, mem_ren, mem_size, mem_sext, dnpc_sel
    );

endinterface

`default_nettype wire

// File: common/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // one-hot alu operation
    typedef enum logic [9:0] {
        ALU_ADD  = 10'b00_0000_0001,
        ALU_SUB  = 10'b00_0000_0010,
        ALU_SLT  = 10'b00_0000_0100,
        ALU_SLTU = 10'b00_0000_1000,
        ALU_XOR  = 10'b00_0001_0000,
        ALU_OR   = 10'b00_0010_0000,
        ALU_AND  = 10'b00_0100_0000,
        ALU_SLL  = 10'b00_1000_0000,
        ALU_SRL  = 10'b01_0000_0000,
        ALU_SRA  = 10'b10_0000_0000
    } alu_op_e;

    typedef enum logic [2:0] {
        OP1_RS1  = 3'b001,
        OP1_PC   = 3'b010,
        OP1_ZERO = 3'b100
    } opnum1_e;

    typedef enum logic [1:0] {
        OP2_RS2 = 2'b01,
        OP2_IMM = 2'b10
    } opnum2_e;

    // write-back source
    typedef enum logic [2:0] {
        REGIN_ALU  = 3'b001,
        REGIN_MEM  = 3'b010,
        REGIN_SNPC = 3'b100
    } regin_e;

    typedef enum logic [3:0] {
        DNPC_SNPC   = 4'b0001,
        DNPC_BRANCH = 4'b0010,
        DNPC_JAL    = 4'b0100,
        DNPC_JALR   = 4'b1000
    } dnpc_e;

    // same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE  = 2'b00,
        MEM_HALF  = 2'b01,
        MEM_WORD  = 2'b10,
        MEM_DWORD = 2'b11
    } mem_size_e;

endpackage

`default_nettype wire

// File: common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data width of the integer core
`define RV_XLEN 64

// architectural register count
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

// ebreak encoding, raises the halted flag
`define RV_EBREAK 32'h0010_0073

`endif

// File: common/rv_isa_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_isa_pkg;

    ////////////////////
    // architectural widths
    ////////////////////

    typedef logic [31:0] inst_t;
    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

    // one strobe bit per byte lane
    typedef logic [`RV_XLEN/8-1:0] strb_t;

    ////////////////////
    // major opcodes
    ////////////////////

    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

endpackage

`default_nettype wire

// File: decoder/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
    input  wire rv_isa_pkg::inst_t     inst,
    input  wire rv_isa_pkg::xlen_t     rs1_data,
    input  wire rv_isa_pkg::xlen_t     rs2_data,
    output rv_isa_pkg::reg_addr_t      rs1,
    output rv_isa_pkg::reg_addr_t      rs2,
    output rv_isa_pkg::reg_addr_t      rd,
    dec_ctrl_if.decoder                ctrl
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                m_ext;
    rv_isa_pkg::xlen_t   imm_i;
    rv_isa_pkg::xlen_t   imm_s;
    rv_isa_pkg::xlen_t   imm_b;
    rv_isa_pkg::xlen_t   imm_u;
    rv_isa_pkg::xlen_t   imm_j;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    logic                br_take;

    // funct3 picks the operation, alt selects sub or sra
    function automatic rv_ctrl_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            3'b001:  return rv_ctrl_pkg::ALU_SLL;
            3'b010:  return rv_ctrl_pkg::ALU_SLT;
            3'b011:  return rv_ctrl_pkg::ALU_SLTU;
            3'b100:  return rv_ctrl_pkg::ALU_XOR;
            3'b101:  return alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'b110:  return rv_ctrl_pkg::ALU_OR;
            default: return rv_ctrl_pkg::ALU_AND;
        endcase
    endfunction

    ////////////////////
    // field extraction
    ////////////////////

    assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // mul/div group, left undecoded
    assign m_ext = (funct7 == 7'b000_0001);

    // immediates, sign extended from bit 31
    assign imm_i = rv_isa_pkg::xlen_t'($signed(inst[31:20]));
    assign imm_s = rv_isa_pkg::xlen_t'($signed({inst[31:25], inst[11:7]}));
    assign imm_b = rv_isa_pkg::xlen_t'($signed({inst[31], inst[7], inst[30:25],
                                                inst[11:8], 1'b0}));
    assign imm_u = rv_isa_pkg::xlen_t'($signed({inst[31:12], 12'b0}));
    assign imm_j = rv_isa_pkg::xlen_t'($signed({inst[31], inst[19:12], inst[20],
                                                inst[30:21], 1'b0}));

    ////////////////////
    // branch decision
    ////////////////////

    assign br_eq  = (rs1_data == rs2_data);
    assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign br_ltu = (rs1_data < rs2_data);

    always_comb begin
        case (funct3)
            3'b000:  br_take = br_eq;
            3'b001:  br_take = !br_eq;
            3'b100:  br_take = br_lt;
            3'b101:  br_take = !br_lt;
            3'b110:  br_take = br_ltu;
            3'b111:  br_take = !br_ltu;
            default: br_take = 1'b0;
        endcase
    end

    ////////////////////
    // control bundle
    ////////////////////

    always_comb begin
        // nop defaults, also used for unknown opcodes
        ctrl.imm        = '0;
        ctrl.alu_op     = rv_ctrl_pkg::ALU_ADD;
        ctrl.opnum1_sel = rv_ctrl_pkg::OP1_RS1;
        ctrl.opnum2_sel = rv_ctrl_pkg::OP2_IMM;
        ctrl.word_op    = 1'b0;
        ctrl.reg_wen    = 1'b0;
        ctrl.regin_sel  = rv_ctrl_pkg::REGIN_ALU;
        ctrl.mem_wen    = 1'b0;
        ctrl.mem_ren    = 1'b0;
        ctrl.mem_size   = rv_ctrl_pkg::mem_size_e'(funct3[1:0]);
        ctrl.mem_sext   = !funct3[2];
        ctrl.dnpc_sel   = rv_ctrl_pkg::DNPC_SNPC;

        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                ctrl.imm        = imm_u;
                ctrl.opnum1_sel = rv_ctrl_pkg::OP1_ZERO;
                ctrl.reg_wen    = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                ctrl.imm        = imm_u;
                ctrl.opnum1_sel = rv_ctrl_pkg::OP1_PC;
                ctrl.reg_wen    = 1'b1;
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.imm        = imm_j;
                ctrl.opnum1_sel = rv_ctrl_pkg::OP1_PC;
                ctrl.reg_wen    = 1'b1;
                ctrl.regin_sel  = rv_ctrl_pkg::REGIN_SNPC;
                ctrl.dnpc_sel   = rv_ctrl_pkg::DNPC_JAL;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.imm       = imm_i;
                ctrl.reg_wen   = 1'b1;
                ctrl.regin_sel = rv_ctrl_pkg::REGIN_SNPC;
                ctrl.dnpc_sel  = rv_ctrl_pkg::DNPC_JALR;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // alu builds the target, decoder picks the path
                ctrl.imm        = imm_b;
                ctrl.opnum1_sel = rv_ctrl_pkg::OP1_PC;
                ctrl.dnpc_sel   = br_take ? rv_ctrl_pkg::DNPC_BRANCH : rv_ctrl_pkg::DNPC_SNPC;
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.imm       = imm_i;
                ctrl.reg_wen   = 1'b1;
                ctrl.mem_ren   = 1'b1;
                ctrl.regin_sel = rv_ctrl_pkg::REGIN_MEM;
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.imm     = imm_s;
                ctrl.mem_wen = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM_32: begin
                // bit 30 only means sra for shifts, never sub
                ctrl.imm     = imm_i;
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = alu_sel(funct3, (funct3 == 3'b101) && inst[30]);
                ctrl.word_op = (opcode == rv_isa_pkg::OPC_OP_IMM_32);
            end
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_32: begin
                ctrl.opnum2_sel = rv_ctrl_pkg::OP2_RS2;
                ctrl.reg_wen    = !m_ext;
                ctrl.alu_op     = alu_sel(funct3, inst[30]);
                ctrl.word_op    = (opcode == rv_isa_pkg::OPC_OP_32);
            end
            default: begin
            end
        endcase

        assert (!(ctrl.reg_wen && ctrl.mem_wen))
            else $error("decoder drives register and memory write together");
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
common/dec_ctrl_if.sv
decoder/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
bench/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o Vrv_core_tb \
    && ./obj_dir/Vrv_core_tb \
    || exit 1

// File: source/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
    dec_ctrl_if.exec               ctrl,
    input  wire rv_isa_pkg::xlen_t pc,
    input  wire rv_isa_pkg::xlen_t rs1_data,
    input  wire rv_isa_pkg::xlen_t rs2_data,
    output rv_isa_pkg::xlen_t      result
);

    rv_isa_pkg::xlen_t op1;
    rv_isa_pkg::xlen_t op2;
    rv_isa_pkg::xlen_t src_zx;
    rv_isa_pkg::xlen_t src_sx;
    rv_isa_pkg::xlen_t raw;
    logic [5:0]        shamt;

    ////////////////////
    // operand select
    ////////////////////

    always_comb begin
        case (ctrl.opnum1_sel)
            rv_ctrl_pkg::OP1_RS1: op1 = rs1_data;
            rv_ctrl_pkg::OP1_PC:  op1 = pc;
            default:              op1 = '0;
        endcase
    end

    assign op2 = (ctrl.opnum2_sel == rv_ctrl_pkg::OP2_RS2) ? rs2_data : ctrl.imm;

    // word forms shift only the low 32 bits by at most 31
    assign src_zx = ctrl.word_op ? {32'b0, op1[31:0]} : op1;
    assign src_sx = ctrl.word_op ? {{32{op1[31]}}, op1[31:0]} : op1;
    assign shamt  = ctrl.word_op ? {1'b0, op2[4:0]} : op2[5:0];

    ////////////////////
    // operations
    ////////////////////

    always_comb begin
        case (ctrl.alu_op)
            rv_ctrl_pkg::ALU_ADD:  raw = op1 + op2;
            rv_ctrl_pkg::ALU_SUB:  raw = op1 - op2;
            rv_ctrl_pkg::ALU_SLT:  raw = rv_isa_pkg::xlen_t'($signed(op1) < $signed(op2));
            rv_ctrl_pkg::ALU_SLTU: raw = rv_isa_pkg::xlen_t'(op1 < op2);
            rv_ctrl_pkg::ALU_XOR:  raw = op1 ^ op2;
            rv_ctrl_pkg::ALU_OR:   raw = op1 | op2;
            rv_ctrl_pkg::ALU_AND:  raw = op1 & op2;
            rv_ctrl_pkg::ALU_SLL:  raw = op1 << shamt;
            rv_ctrl_pkg::ALU_SRL:  raw = src_zx >> shamt;
            rv_ctrl_pkg::ALU_SRA:  raw = rv_isa_pkg::xlen_t'($signed(src_sx) >>> shamt);
            default:               raw = '0;
        endcase
    end

    // W results are sign extended from bit 31
    assign result = ctrl.word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_core (
    input  wire logic              I_sys_clk,
    input  wire logic              rst_n,
    output rv_isa_pkg::xlen_t      imem_addr,
    input  wire rv_isa_pkg::inst_t imem_data,
    output rv_isa_pkg::xlen_t      dmem_addr,
    output logic                   dmem_wen,
    output rv_isa_pkg::strb_t      dmem_wstrb,
    output rv_isa_pkg::xlen_t      dmem_wdata,
    input  wire rv_isa_pkg::xlen_t dmem_rdata,
    output logic                   halted
);

    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::xlen_t     snpc;
    rv_isa_pkg::xlen_t     next_pc;
    rv_isa_pkg::xlen_t     rs1_data;
    rv_isa_pkg::xlen_t     rs2_data;
    rv_isa_pkg::xlen_t     alu_result;
    rv_isa_pkg::xlen_t     load_data;
    rv_isa_pkg::xlen_t     rd_data;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::reg_addr_t rd;
    logic                  is_ebreak;
    logic                  rf_wen;

    dec_ctrl_if ctrl ();

    assign imem_addr = pc;
    assign snpc      = pc + 64'd4;
    assign is_ebreak = (imem_data == `RV_EBREAK);

    ////////////////////
    // next pc and write-back
    ////////////////////

    always_comb begin
        case (ctrl.dnpc_sel)
            rv_ctrl_pkg::DNPC_BRANCH,
            rv_ctrl_pkg::DNPC_JAL:  next_pc = alu_result;
            rv_ctrl_pkg::DNPC_JALR: next_pc = {alu_result[$bits(alu_result)-1:1], 1'b0};
            default:                next_pc = snpc;
        endcase
    end

    always_comb begin
        case (ctrl.regin_sel)
            rv_ctrl_pkg::REGIN_MEM:  rd_data = load_data;
            rv_ctrl_pkg::REGIN_SNPC: rd_data = snpc;
            default:                 rd_data = alu_result;
        endcase
    end

    assign rf_wen = ctrl.reg_wen && !halted;

    // pc stays on the ebreak once it is fetched
    always_ff @(posedge I_sys_clk) begin
        if (!rst_n) begin
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (is_ebreak) begin
                halted <= 1'b1;
            end
            if (!halted && !is_ebreak) begin
                pc <= next_pc;
            end
        end
    end

    ////////////////////
    // instances
    ////////////////////

    rv_decoder decoder_i (
        .inst     (imem_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .ctrl     (ctrl.decoder)
    );

    rv_regfile regfile_i (
        .I_sys_clk (I_sys_clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wen       (rf_wen),
        .rd        (rd),
        .rd_data   (rd_data)
    );

    rv_alu alu_i (
        .ctrl     (ctrl.exec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    rv_lsu lsu_i (
        .ctrl       (ctrl.exec),
        .addr       (alu_result),
        .store_data (rs2_data),
        .mem_rdata  (dmem_rdata),
        .halted     (halted),
        .dmem_addr  (dmem_addr),
        .dmem_wen   (dmem_wen),
        .dmem_wstrb (dmem_wstrb),
        .dmem_wdata (dmem_wdata),
        .load_data  (load_data)
    );

    // no compressed forms, so every fetch address is word aligned
    pc_word_aligned: assert property (
        @(posedge I_sys_clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc left word alignment");

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
    dec_ctrl_if.exec               ctrl,
    input  wire rv_isa_pkg::xlen_t addr,
    input  wire rv_isa_pkg::xlen_t store_data,
    input  wire rv_isa_pkg::xlen_t mem_rdata,
    input  wire logic              halted,
    output rv_isa_pkg::xlen_t      dmem_addr,
    output logic                   dmem_wen,
    output rv_isa_pkg::strb_t      dmem_wstrb,
    output rv_isa_pkg::xlen_t      dmem_wdata,
    output rv_isa_pkg::xlen_t      load_data
);

    logic [2:0]        lane;
    logic [5:0]        lane_bits;
    rv_isa_pkg::strb_t size_mask;
    rv_isa_pkg::xlen_t lane_data;
    rv_isa_pkg::xlen_t ext_data;

    // memory is addressed in doublewords
    assign dmem_addr = {addr[$bits(addr)-1:3], 3'b000};
    assign lane      = addr[2:0];
    assign lane_bits = {lane, 3'b000};

    ////////////////////
    // store path
    ////////////////////

    always_comb begin
        case (ctrl.mem_size)
            rv_ctrl_pkg::MEM_BYTE: size_mask = 8'h01;
            rv_ctrl_pkg::MEM_HALF: size_mask = 8'h03;
            rv_ctrl_pkg::MEM_WORD: size_mask = 8'h0f;
            default:               size_mask = 8'hff;
        endcase
    end

    assign dmem_wstrb = size_mask << lane;
    assign dmem_wdata = store_data << lane_bits;
    assign dmem_wen   = ctrl.mem_wen && !halted;

    ////////////////////
    // load path
    ////////////////////

    assign lane_data = mem_rdata >> lane_bits;

    always_comb begin
        case (ctrl.mem_size)
            rv_ctrl_pkg::MEM_BYTE: begin
                ext_data = ctrl.mem_sext ? {{56{lane_data[7]}}, lane_data[7:0]}
                                         : {56'b0, lane_data[7:0]};
            end
            rv_ctrl_pkg::MEM_HALF: begin
                ext_data = ctrl.mem_sext ? {{48{lane_data[15]}}, lane_data[15:0]}
                                         : {48'b0, lane_data[15:0]};
            end
            rv_ctrl_pkg::MEM_WORD: begin
                ext_data = ctrl.mem_sext ? {{32{lane_data[31]}}, lane_data[31:0]}
                                         : {32'b0, lane_data[31:0]};
            end
            default: ext_data = lane_data;
        endcase
    end

    assign load_data = ctrl.mem_ren ? ext_data : '0;

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
    input  wire logic                  I_sys_clk,
    input  wire logic                  rst_n,
    input  wire rv_isa_pkg::reg_addr_t rs1,
    input  wire rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::xlen_t          rs1_data,
    output rv_isa_pkg::xlen_t          rs2_data,
    input  wire logic                  wen,
    input  wire rv_isa_pkg::reg_addr_t rd,
    input  wire rv_isa_pkg::xlen_t     rd_data
);

    rv_isa_pkg::xlen_t regs [`RV_NREGS];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge I_sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // a write aimed at x0 leaves both read ports at zero for x0
    x0_stays_zero: assert property (
        @(posedge I_sys_clk) disable iff (!rst_n)
        (wen && (rd == '0)) |=> ((rs1 != '0) || (rs1_data == '0)) &&
                                ((rs2 != '0) || (rs2_data == '0))
    ) else $error("x0 reads nonzero after a write to it");

endmodule

`default_nettype wire
